// ==== hdl/csi2_pkg.sv ====
// Packet-level types and data-type codes of the MIPI CSI-2 receiver interface.
// Referenced by scoped name from the decoder, the top level and the testbench.

package csi2_pkg;

    typedef logic [5:0]  csi2_data_type_t;   // Packet header data type
    typedef logic [15:0] csi2_word_count_t;  // Long-packet payload length in bytes
    typedef logic [7:0]  csi2_byte_t;        // One payload byte

    // Short packet codes
    localparam csi2_data_type_t CSI2_DT_FRAME_START = 6'h00;
    localparam csi2_data_type_t CSI2_DT_FRAME_END   = 6'h01;

    // Long packet codes
    localparam csi2_data_type_t CSI2_DT_RAW10       = 6'h2B;

endpackage

// ==== hdl/camera_pkg.sv ====
// Pixel, coordinate and metering types shared by the pixel stages of the front end.
// Also holds the RAW10 group geometry used by the unpacker and the testbench model.

package camera_pkg;

    typedef logic [9:0]  pixel_t;         // One RAW10 pixel
    typedef logic [11:0] pixel_coord_t;   // Column or row index, crop bounds
    typedef logic [23:0] pixel_count_t;   // Metered pixels per frame
    typedef logic [31:0] metering_sum_t;  // Sum of metered pixels per frame

    // A RAW10 group is four MSB bytes followed by one byte of packed LSBs
    localparam int RAW10_GROUP_BYTES  = 5;
    localparam int RAW10_GROUP_PIXELS = 4;

endpackage

// ==== hdl/csi2_packet_decoder.sv ====
// Turns CSI-2 receiver header and payload strobes into a framed RAW10 byte stream.
// Frame level follows the frame start and end short packets, line level follows
// accepted RAW10 long packets. Other data types and stray payload are dropped.

`timescale 1ns/1ps

module csi2_packet_decoder (
    input  logic                        mipi_byte_clock,
    input  logic                        mipi_byte_reset_n,

    input  logic                        sp_en_i,
    input  logic                        lp_av_en_i,
    input  csi2_pkg::csi2_data_type_t   dt_i,
    input  csi2_pkg::csi2_word_count_t  wc_i,

    input  logic                        payload_en_i,
    input  csi2_pkg::csi2_byte_t        payload_i,

    output logic                        frame_valid_o,
    output logic                        line_valid_o,
    output logic                        byte_valid_o,
    output csi2_pkg::csi2_byte_t        byte_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FRAME,
        ST_LINE
    } decoder_state_t;

    decoder_state_t             state;
    csi2_pkg::csi2_word_count_t byte_count;  // Payload bytes still to come
    logic                       frame_start;
    logic                       frame_end;
    logic                       raw10_header;

    assign frame_start  = sp_en_i && (dt_i == csi2_pkg::CSI2_DT_FRAME_START);
    assign frame_end    = sp_en_i && (dt_i == csi2_pkg::CSI2_DT_FRAME_END);
    assign raw10_header = lp_av_en_i && (dt_i == csi2_pkg::CSI2_DT_RAW10) && (wc_i != '0);

    // Levels decode straight from the state register
    assign frame_valid_o = (state != ST_IDLE);
    assign line_valid_o  = (state == ST_LINE);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state        <= ST_IDLE;
            byte_count   <= '0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (frame_start) begin
                        state <= ST_FRAME;
                    end
                end

                ST_FRAME: begin
                    if (frame_end) begin
                        state <= ST_IDLE;
                    end else if (raw10_header) begin
                        state      <= ST_LINE;
                        byte_count <= wc_i;
                    end
                end

                ST_LINE: begin
                    if (frame_end) begin
                        state <= ST_IDLE;  // Truncated line
                    end else if (payload_en_i) begin
                        byte_valid_o <= 1'b1;
                        byte_count   <= byte_count - 1'b1;
                        if (byte_count == csi2_pkg::csi2_word_count_t'(1)) begin
                            state <= ST_FRAME;  // Line drops with the last byte
                        end
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (payload_en_i) begin
            byte_o <= payload_i;
        end
    end

endmodule

// ==== hdl/raw10_unpacker.sv ====
// Unpacks 5-byte RAW10 groups into 10-bit pixels, one pixel per cycle.
// A finished group moves to a drain register so the next group can be collected
// while it empties. Line and frame levels stretch until the drain is empty.

`timescale 1ns/1ps

module raw10_unpacker (
    input  logic                  mipi_byte_clock,
    input  logic                  mipi_byte_reset_n,

    input  logic                  frame_valid_i,
    input  logic                  line_valid_i,
    input  logic                  byte_valid_i,
    input  csi2_pkg::csi2_byte_t  byte_i,

    output logic                  frame_valid_o,
    output logic                  line_valid_o,
    output logic                  pixel_valid_o,
    output camera_pkg::pixel_t    pixel_o
);

    csi2_pkg::csi2_byte_t msb_bytes [camera_pkg::RAW10_GROUP_PIXELS];
    camera_pkg::pixel_t   drain [camera_pkg::RAW10_GROUP_PIXELS - 1];
    logic [2:0]           byte_index;
    logic [2:0]           group_index;  // Position of the current byte in its group
    logic [1:0]           drain_left;
    logic                 line_valid_d;
    logic                 line_start;
    logic                 group_done;
    logic                 pixel_next;
    logic                 line_next;

    assign line_start  = line_valid_i && !line_valid_d;
    assign group_index = line_start ? 3'd0 : byte_index;
    assign group_done  = byte_valid_i &&
                         (group_index == 3'(camera_pkg::RAW10_GROUP_BYTES - 1));
    assign pixel_next  = group_done || (drain_left != 2'd0);
    assign line_next   = line_valid_i || pixel_next;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            line_valid_d  <= 1'b0;
            byte_index    <= 3'd0;
            drain_left    <= 2'd0;
            frame_valid_o <= 1'b0;
            line_valid_o  <= 1'b0;
            pixel_valid_o <= 1'b0;
        end else begin
            line_valid_d  <= line_valid_i;
            line_valid_o  <= line_next;
            frame_valid_o <= frame_valid_i || line_next;
            pixel_valid_o <= pixel_next;

            if (group_done) begin
                byte_index <= 3'd0;
                drain_left <= 2'(camera_pkg::RAW10_GROUP_PIXELS - 1);
            end else begin
                if (byte_valid_i) begin
                    byte_index <= group_index + 3'd1;
                end else if (line_start) begin
                    byte_index <= 3'd0;
                end
                if (drain_left != 2'd0) begin
                    drain_left <= drain_left - 2'd1;
                end
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (byte_valid_i && !group_done) begin
            msb_bytes[group_index[1:0]] <= byte_i;
        end

        if (group_done) begin
            // LSB byte holds two bits per pixel, pixel 0 in bits 1:0
            pixel_o <= {msb_bytes[0], byte_i[1:0]};
            for (int k = 1; k < camera_pkg::RAW10_GROUP_PIXELS; k++) begin
                drain[k - 1] <= {msb_bytes[k], byte_i[2 * k +: 2]};
            end
        end else if (drain_left != 2'd0) begin
            pixel_o <= drain[0];
            for (int k = 0; k < camera_pkg::RAW10_GROUP_PIXELS - 2; k++) begin
                drain[k] <= drain[k + 1];
            end
        end
    end

endmodule

// ==== hdl/window_crop.sv ====
// Passes only the pixels inside a programmed window, start bounds inclusive and
// end bounds exclusive. Bounds are sampled at frame start and hold for the frame.

`timescale 1ns/1ps

module window_crop (
    input  logic                      mipi_byte_clock,
    input  logic                      mipi_byte_reset_n,

    input  camera_pkg::pixel_coord_t  x_start_i,
    input  camera_pkg::pixel_coord_t  x_end_i,
    input  camera_pkg::pixel_coord_t  y_start_i,
    input  camera_pkg::pixel_coord_t  y_end_i,

    input  logic                      frame_valid_i,
    input  logic                      line_valid_i,
    input  logic                      pixel_valid_i,
    input  camera_pkg::pixel_t        pixel_i,

    output logic                      frame_valid_o,
    output logic                      line_valid_o,
    output logic                      pixel_valid_o,
    output camera_pkg::pixel_t        pixel_o
);

    camera_pkg::pixel_coord_t x_start;
    camera_pkg::pixel_coord_t x_end;
    camera_pkg::pixel_coord_t y_start;
    camera_pkg::pixel_coord_t y_end;
    camera_pkg::pixel_coord_t x_count;
    camera_pkg::pixel_coord_t y_count;
    camera_pkg::pixel_coord_t column;
    logic                     frame_valid_d;
    logic                     line_valid_d;
    logic                     frame_start;
    logic                     line_start;
    logic                     line_end;
    logic                     in_rows;
    logic                     in_cols;

    assign frame_start = frame_valid_i && !frame_valid_d;
    assign line_start  = line_valid_i && !line_valid_d;
    assign line_end    = !line_valid_i && line_valid_d;
    assign column      = line_start ? '0 : x_count;

    assign in_rows = (y_count >= y_start) && (y_count < y_end);
    assign in_cols = (column >= x_start) && (column < x_end);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_d <= 1'b0;
            line_valid_d  <= 1'b0;
            x_start       <= '0;
            x_end         <= '0;
            y_start       <= '0;
            y_end         <= '0;
            x_count       <= '0;
            y_count       <= '0;
            frame_valid_o <= 1'b0;
            line_valid_o  <= 1'b0;
            pixel_valid_o <= 1'b0;
        end else begin
            frame_valid_d <= frame_valid_i;
            line_valid_d  <= line_valid_i;

            if (frame_start) begin
                x_start <= x_start_i;
                x_end   <= x_end_i;
                y_start <= y_start_i;
                y_end   <= y_end_i;
                y_count <= '0;
            end else if (line_end) begin
                y_count <= y_count + 1'b1;
            end

            if (pixel_valid_i) begin
                x_count <= column + 1'b1;
            end else if (line_start) begin
                x_count <= '0;
            end

            frame_valid_o <= frame_valid_i;
            line_valid_o  <= line_valid_i && in_rows;
            pixel_valid_o <= pixel_valid_i && in_rows && in_cols;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        pixel_o <= pixel_i;
    end

endmodule

// ==== hdl/frame_metering.sv ====
// Meters the pixels of each frame as sum, count and peak value.
// Results update and metering_ready_o pulses one cycle after frame_valid_i falls.

`timescale 1ns/1ps

module frame_metering (
    input  logic                       mipi_byte_clock,
    input  logic                       mipi_byte_reset_n,

    input  logic                       frame_valid_i,
    input  logic                       line_valid_i,
    input  logic                       pixel_valid_i,
    input  camera_pkg::pixel_t         pixel_i,

    output camera_pkg::metering_sum_t  pixel_sum_o,
    output camera_pkg::pixel_count_t   pixel_count_o,
    output camera_pkg::pixel_t         pixel_peak_o,
    output logic                       metering_ready_o
);

    camera_pkg::metering_sum_t sum_acc;
    camera_pkg::pixel_count_t  count_acc;
    camera_pkg::pixel_t        peak_acc;
    camera_pkg::metering_sum_t sum_base;
    camera_pkg::pixel_count_t  count_base;
    camera_pkg::pixel_t        peak_base;
    logic                      frame_valid_d;
    logic                      frame_start;
    logic                      frame_end;
    logic                      pixel_take;

    assign frame_start = frame_valid_i && !frame_valid_d;
    assign frame_end   = !frame_valid_i && frame_valid_d;
    assign pixel_take  = pixel_valid_i && line_valid_i;

    // New frame starts from zero
    assign sum_base   = frame_start ? '0 : sum_acc;
    assign count_base = frame_start ? '0 : count_acc;
    assign peak_base  = frame_start ? '0 : peak_acc;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_d    <= 1'b0;
            sum_acc          <= '0;
            count_acc        <= '0;
            peak_acc         <= '0;
            pixel_sum_o      <= '0;
            pixel_count_o    <= '0;
            pixel_peak_o     <= '0;
            metering_ready_o <= 1'b0;
        end else begin
            frame_valid_d    <= frame_valid_i;
            metering_ready_o <= frame_end;

            if (pixel_take) begin
                sum_acc   <= sum_base + camera_pkg::metering_sum_t'(pixel_i);
                count_acc <= count_base + 1'b1;
                peak_acc  <= (pixel_i > peak_base) ? pixel_i : peak_base;
            end else if (frame_start) begin
                sum_acc   <= '0;
                count_acc <= '0;
                peak_acc  <= '0;
            end

            if (frame_end) begin
                pixel_sum_o   <= sum_acc;
                pixel_count_o <= count_acc;
                pixel_peak_o  <= peak_acc;
            end
        end
    end

endmodule

// ==== hdl/camera_frontend.sv ====
// Byte-clock camera front end: CSI-2 packet decode, RAW10 unpack, window crop
// and frame metering in a chain. Crop bounds are taken at each frame start.

`timescale 1ns/1ps

module camera_frontend (
    input  logic                        mipi_byte_clock,
    input  logic                        mipi_byte_reset_n,

    input  logic                        sp_en_i,
    input  logic                        lp_av_en_i,
    input  csi2_pkg::csi2_data_type_t   dt_i,
    input  csi2_pkg::csi2_word_count_t  wc_i,
    input  logic                        payload_en_i,
    input  csi2_pkg::csi2_byte_t        payload_i,

    input  camera_pkg::pixel_coord_t    x_start_i,
    input  camera_pkg::pixel_coord_t    x_end_i,
    input  camera_pkg::pixel_coord_t    y_start_i,
    input  camera_pkg::pixel_coord_t    y_end_i,

    output camera_pkg::metering_sum_t   pixel_sum_o,
    output camera_pkg::pixel_count_t    pixel_count_o,
    output camera_pkg::pixel_t          pixel_peak_o,
    output logic                        metering_ready_o
);

    logic                 decoded_frame_valid;
    logic                 decoded_line_valid;
    logic                 decoded_byte_valid;
    csi2_pkg::csi2_byte_t decoded_byte;

    logic                 unpacked_frame_valid;
    logic                 unpacked_line_valid;
    logic                 unpacked_pixel_valid;
    camera_pkg::pixel_t   unpacked_pixel;

    logic                 cropped_frame_valid;
    logic                 cropped_line_valid;
    logic                 cropped_pixel_valid;
    camera_pkg::pixel_t   cropped_pixel;

    csi2_packet_decoder u_decoder (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .sp_en_i           (sp_en_i),
        .lp_av_en_i        (lp_av_en_i),
        .dt_i              (dt_i),
        .wc_i              (wc_i),
        .payload_en_i      (payload_en_i),
        .payload_i         (payload_i),
        .frame_valid_o     (decoded_frame_valid),
        .line_valid_o      (decoded_line_valid),
        .byte_valid_o      (decoded_byte_valid),
        .byte_o            (decoded_byte)
    );

    raw10_unpacker u_unpacker (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (decoded_frame_valid),
        .line_valid_i      (decoded_line_valid),
        .byte_valid_i      (decoded_byte_valid),
        .byte_i            (decoded_byte),
        .frame_valid_o     (unpacked_frame_valid),
        .line_valid_o      (unpacked_line_valid),
        .pixel_valid_o     (unpacked_pixel_valid),
        .pixel_o           (unpacked_pixel)
    );

    window_crop u_crop (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .x_start_i         (x_start_i),
        .x_end_i           (x_end_i),
        .y_start_i         (y_start_i),
        .y_end_i           (y_end_i),
        .frame_valid_i     (unpacked_frame_valid),
        .line_valid_i      (unpacked_line_valid),
        .pixel_valid_i     (unpacked_pixel_valid),
        .pixel_i           (unpacked_pixel),
        .frame_valid_o     (cropped_frame_valid),
        .line_valid_o      (cropped_line_valid),
        .pixel_valid_o     (cropped_pixel_valid),
        .pixel_o           (cropped_pixel)
    );

    frame_metering u_metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (cropped_frame_valid),
        .line_valid_i      (cropped_line_valid),
        .pixel_valid_i     (cropped_pixel_valid),
        .pixel_i           (cropped_pixel),
        .pixel_sum_o       (pixel_sum_o),
        .pixel_count_o     (pixel_count_o),
        .pixel_peak_o      (pixel_peak_o),
        .metering_ready_o  (metering_ready_o)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
// Clock and reset source for the camera front end testbench.
// 10 ns byte clock, reset held low for 5 cycles and released on a falling edge.

`timescale 1ns/1ps

module tb_clock_gen (
    output logic mipi_byte_clock,
    output logic mipi_byte_reset_n
);

    localparam int RESET_CYCLES = 5;

    initial begin
        mipi_byte_clock = 1'b0;
        forever #5 mipi_byte_clock = ~mipi_byte_clock;  // 10 ns period
    end

    initial begin
        mipi_byte_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge mipi_byte_clock);
        @(negedge mipi_byte_clock);
        mipi_byte_reset_n = 1'b1;
    end

endmodule

// ==== tests/tb_camera_frontend.sv ====
// Directed testbench for the camera front end. Sends CSI-2 packets, models RAW10
// unpacking and window cropping, and compares each frame's metering results.

`timescale 1ns/1ps

module tb_camera_frontend;

    localparam int STIM_BYTES  = 20 + 120 + 40 + 160 + 70;  // Payload bytes of tests 2 to 6
    localparam int CYCLE_LIMIT = 4 * STIM_BYTES + 200;
    localparam int LINE_GAP    = 8;  // Lets the unpacker drain between lines

    logic                       mipi_byte_clock;
    logic                       mipi_byte_reset_n;
    logic                       sp_en;
    logic                       lp_av_en;
    csi2_pkg::csi2_data_type_t  dt;
    csi2_pkg::csi2_word_count_t wc;
    logic                       payload_en;
    csi2_pkg::csi2_byte_t       payload;
    camera_pkg::pixel_coord_t   x_start;
    camera_pkg::pixel_coord_t   x_end;
    camera_pkg::pixel_coord_t   y_start;
    camera_pkg::pixel_coord_t   y_end;
    camera_pkg::metering_sum_t  pixel_sum;
    camera_pkg::pixel_count_t   pixel_count;
    camera_pkg::pixel_t         pixel_peak;
    logic                       metering_ready;

    csi2_pkg::csi2_byte_t       frame_mem [160];
    camera_pkg::metering_sum_t  exp_sum_q [$];
    camera_pkg::pixel_count_t   exp_count_q [$];
    camera_pkg::pixel_t         exp_peak_q [$];
    camera_pkg::metering_sum_t  seen_sum_q [$];
    camera_pkg::pixel_count_t   seen_count_q [$];
    camera_pkg::pixel_t         seen_peak_q [$];
    integer                     seed = 32'hfa71_7d68;
    int                         cycle_count = 0;

    tb_clock_gen u_clock_gen (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n)
    );

    camera_frontend u_dut (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .sp_en_i           (sp_en),
        .lp_av_en_i        (lp_av_en),
        .dt_i              (dt),
        .wc_i              (wc),
        .payload_en_i      (payload_en),
        .payload_i         (payload),
        .x_start_i         (x_start),
        .x_end_i           (x_end),
        .y_start_i         (y_start),
        .y_end_i           (y_end),
        .pixel_sum_o       (pixel_sum),
        .pixel_count_o     (pixel_count),
        .pixel_peak_o      (pixel_peak),
        .metering_ready_o  (metering_ready)
    );

    always @(negedge mipi_byte_clock) begin
        if (mipi_byte_reset_n && metering_ready) begin  // Results are stable mid-cycle
            seen_sum_q.push_back(pixel_sum);
            seen_count_q.push_back(pixel_count);
            seen_peak_q.push_back(pixel_peak);
        end
        cycle_count++;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the metering ready pulse never came",
                     CYCLE_LIMIT);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_sum(input camera_pkg::metering_sum_t actual,
                             input camera_pkg::metering_sum_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s pixel sum %0d, expected %0d",
                     $time, what, actual, expected);
            fail_run();
        end
    endtask

    task automatic check_count(input camera_pkg::pixel_count_t actual,
                               input camera_pkg::pixel_count_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s pixel count %0d, expected %0d",
                     $time, what, actual, expected);
            fail_run();
        end
    endtask

    task automatic check_peak(input camera_pkg::pixel_t actual,
                              input camera_pkg::pixel_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s pixel peak %0d, expected %0d",
                     $time, what, actual, expected);
            fail_run();
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge mipi_byte_clock);
            sp_en      = 1'b0;
            lp_av_en   = 1'b0;
            payload_en = 1'b0;
        end
    endtask

    task automatic send_short(input csi2_pkg::csi2_data_type_t data_type);
        @(negedge mipi_byte_clock);
        sp_en = 1'b1;
        dt    = data_type;
        idle(2);
    endtask

    // Header, then len bytes from frame_mem, with optional one-cycle gaps
    task automatic send_long(input csi2_pkg::csi2_data_type_t data_type, input int start,
                             input int len, input bit gaps);
        @(negedge mipi_byte_clock);
        lp_av_en = 1'b1;
        dt       = data_type;
        wc       = csi2_pkg::csi2_word_count_t'(len);
        for (int i = 0; i < len; i++) begin
            if (gaps && (($random(seed) & 3) == 0)) begin
                @(negedge mipi_byte_clock);
                lp_av_en   = 1'b0;
                payload_en = 1'b0;
            end
            @(negedge mipi_byte_clock);
            lp_av_en   = 1'b0;
            payload_en = 1'b1;
            payload    = frame_mem[start + i];
        end
        idle(LINE_GAP);
    endtask

    task automatic send_frame(input int start, input int lines, input int len, input bit gaps);
        send_short(csi2_pkg::CSI2_DT_FRAME_START);
        for (int r = 0; r < lines; r++) begin
            send_long(csi2_pkg::CSI2_DT_RAW10, start + r * len, len, gaps);
        end
        send_short(csi2_pkg::CSI2_DT_FRAME_END);
    endtask

    task automatic set_window(input int xs, input int xe, input int ys, input int ye);
        @(negedge mipi_byte_clock);
        x_start = camera_pkg::pixel_coord_t'(xs);
        x_end   = camera_pkg::pixel_coord_t'(xe);
        y_start = camera_pkg::pixel_coord_t'(ys);
        y_end   = camera_pkg::pixel_coord_t'(ye);
    endtask

    task automatic fill_pattern(input int start, input int len, input int salt);
        for (int i = start; i < start + len; i++) begin
            frame_mem[i] = csi2_pkg::csi2_byte_t'(i * 37 + (i >> 5) + salt);
        end
    endtask

    // Reference model over the current window, queued in frame order
    task automatic expect_frame(input int start, input int lines, input int len);
        camera_pkg::metering_sum_t sum;
        camera_pkg::pixel_count_t  count;
        camera_pkg::pixel_t        peak;
        camera_pkg::pixel_t        pix;
        int                        base;
        int                        col;
        sum   = '0;
        count = '0;
        peak  = '0;
        for (int r = 0; r < lines; r++) begin
            for (int g = 0; g < len / camera_pkg::RAW10_GROUP_BYTES; g++) begin
                base = start + r * len + g * camera_pkg::RAW10_GROUP_BYTES;
                for (int k = 0; k < camera_pkg::RAW10_GROUP_PIXELS; k++) begin
                    pix = {frame_mem[base + k], frame_mem[base + 4][2 * k +: 2]};
                    col = g * camera_pkg::RAW10_GROUP_PIXELS + k;
                    if (col >= x_start && col < x_end && r >= y_start && r < y_end) begin
                        sum   = sum + pix;
                        count = count + 1'b1;
                        peak  = (pix > peak) ? pix : peak;
                    end
                end
            end
        end
        exp_sum_q.push_back(sum);
        exp_count_q.push_back(count);
        exp_peak_q.push_back(peak);
    endtask

    task automatic check_next_result(input string what,
                                     output camera_pkg::pixel_count_t count_seen);
        while (seen_sum_q.size() == 0) begin
            @(negedge mipi_byte_clock);
        end
        if (exp_sum_q.size() == 0) begin
            $display("A metering ready pulse came with no frame expected (%s)", what);
            fail_run();
        end
        count_seen = seen_count_q[0];
        check_sum(seen_sum_q.pop_front(), exp_sum_q.pop_front(), what);
        check_count(seen_count_q.pop_front(), exp_count_q.pop_front(), what);
        check_peak(seen_peak_q.pop_front(), exp_peak_q.pop_front(), what);
    endtask

    task automatic test_reset_quiet();
        idle(20);
        if (seen_sum_q.size() != 0) begin
            $display("Metering ready pulsed before any frame was sent");
            fail_run();
        end
        check_sum(pixel_sum, '0, "after reset");
        check_count(pixel_count, '0, "after reset");
        check_peak(pixel_peak, '0, "after reset");
    endtask

    task automatic test_unpack();
        camera_pkg::pixel_count_t count_seen;
        fill_pattern(0, 20, 17);
        set_window(0, 12'hfff, 0, 12'hfff);
        expect_frame(0, 2, 10);
        send_frame(0, 2, 10, 1'b0);
        check_next_result("unpack", count_seen);
        check_count(count_seen, 16, "unpack");
    endtask

    task automatic test_crop();
        camera_pkg::pixel_count_t count_seen;
        fill_pattern(0, 120, 91);
        set_window(3, 13, 1, 4);
        expect_frame(0, 6, 20);
        send_frame(0, 6, 20, 1'b0);
        check_next_result("crop", count_seen);
    endtask

    task automatic test_filter();
        camera_pkg::pixel_count_t count_seen;
        fill_pattern(0, 20, 60);
        for (int i = 20; i < 30; i++) begin
            frame_mem[i] = 8'hff;  // Full-scale pixels show up if leaked
        end
        set_window(0, 12'hfff, 0, 12'hfff);
        expect_frame(0, 2, 10);
        send_long(csi2_pkg::CSI2_DT_RAW10, 20, 10, 1'b0);  // Outside any frame
        send_short(csi2_pkg::CSI2_DT_FRAME_START);
        send_long(csi2_pkg::CSI2_DT_RAW10, 0, 10, 1'b0);
        send_long(csi2_pkg::csi2_data_type_t'(6'h12), 20, 10, 1'b0);
        send_long(csi2_pkg::CSI2_DT_RAW10, 10, 10, 1'b0);
        send_short(csi2_pkg::CSI2_DT_FRAME_END);
        check_next_result("filter", count_seen);
    endtask

    task automatic test_random_gaps();
        camera_pkg::pixel_count_t count_seen;
        for (int i = 0; i < 160; i++) begin
            frame_mem[i] = csi2_pkg::csi2_byte_t'($random(seed));
        end
        set_window(2, 14, 1, 7);
        expect_frame(0, 8, 20);
        send_frame(0, 8, 20, 1'b1);
        check_next_result("random gaps", count_seen);
    endtask

    task automatic test_back_to_back();
        camera_pkg::pixel_count_t count_seen;
        fill_pattern(0, 70, 5);
        set_window(2, 6, 1, 3);
        expect_frame(0, 4, 10);
        send_frame(0, 4, 10, 1'b0);
        set_window(0, 8, 0, 3);
        expect_frame(40, 3, 10);
        send_frame(40, 3, 10, 1'b0);
        check_next_result("first of two frames", count_seen);
        check_count(count_seen, 8, "first window area");
        check_next_result("second of two frames", count_seen);
        check_count(count_seen, 24, "second window area");
    endtask

    initial begin
        sp_en      = 1'b0;
        lp_av_en   = 1'b0;
        dt         = '0;
        wc         = '0;
        payload_en = 1'b0;
        payload    = '0;
        x_start    = '0;
        x_end      = '0;
        y_start    = '0;
        y_end      = '0;
        @(posedge mipi_byte_reset_n);
        test_reset_quiet();
        test_unpack();
        test_crop();
        test_filter();
        test_random_gaps();
        test_back_to_back();
        idle(20);
        if (seen_sum_q.size() != 0) begin
            $display("An extra metering ready pulse came after the last frame");
            fail_run();
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// ==== project.f ====
hdl/csi2_pkg.sv
hdl/camera_pkg.sv
hdl/csi2_packet_decoder.sv
hdl/raw10_unpacker.sv
hdl/window_crop.sv
hdl/frame_metering.sv
hdl/camera_frontend.sv
tests/tb_clock_gen.sv
tests/tb_camera_frontend.sv

// ==== Bender.yml ====
package:
  name: camera_frontend

sources:
  - files:
      - hdl/csi2_pkg.sv
      - hdl/camera_pkg.sv
      - hdl/csi2_packet_decoder.sv
      - hdl/raw10_unpacker.sv
      - hdl/window_crop.sv
      - hdl/frame_metering.sv
      - hdl/camera_frontend.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_camera_frontend.sv
